// File: filelist.f
hdl/cpu_pkg.sv
hdl/ifu.sv
hdl/idu.sv
hdl/exeu.sv
hdl/memu.sv
hdl/wbu.sv
hdl/cpu.sv
test/cpu_assertions.sv
test/cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build the CPU testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module cpu_tb \
	-f filelist.f -o cpu_tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cpu_tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
fi
exit 1

// File: test/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	localparam int PROG_LEN = 35;
	localparam int NUM_STORES = 11;
	localparam int DMEM_WORDS = 64;
	localparam int RESET_CYCLES = 10;
	localparam int CLK_HALF_NS = 10;
	localparam int HALT_HOLD_CYCLES = 20;
	localparam int WATCHDOG_NS = NUM_STORES * 40 * 20;
	localparam logic [31:0] SEED = 32'haffc6df5;
	localparam word_t EBREAK_WORD = 32'h0010_0073;

	typedef struct packed {
		word_t addr;
		word_t data;
	} store_t;

	logic clk;
	logic rst;
	word_t imem_addr;
	word_t imem_rdata;
	word_t word_idx;
	logic dmem_valid;
	dmem_req_t dmem_req;
	logic dmem_ready;
	word_t dmem_rdata;
	logic halted;

	word_t prog [PROG_LEN];
	word_t dmem [DMEM_WORDS];
	store_t exp_stores [NUM_STORES];
	store_t seen_q [$];
	logic req_pending;
	int wait_cnt;

	cpu i_cpu (
		.clk(clk),
		.rst(rst),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.dmem_valid(dmem_valid),
		.dmem_req(dmem_req),
		.dmem_ready(dmem_ready),
		.dmem_rdata(dmem_rdata),
		.halted(halted)
	);

	always #CLK_HALF_NS clk = ~clk;

	// Past the end of the program the ROM returns EBREAK
	assign word_idx = imem_addr >> 2;
	assign imem_rdata = (word_idx < PROG_LEN) ? prog[word_idx[5:0]] : EBREAK_WORD;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "%s", msg);
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			fail_run($sformatf("mismatch at %0t: %s got %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			fail_run($sformatf("mismatch at %0t: %s got %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	task automatic serve_request();
		word_t addr;
		addr = dmem_req.addr;
		if (addr >= DMEM_WORDS * 4 || addr[1:0] != 2'b00) begin
			fail_run($sformatf("data access to address %h is outside memory or misaligned", addr));
		end
		if (dmem_req.we) begin
			dmem[addr[7:2]] = dmem_req.wdata;
			seen_q.push_back({addr, dmem_req.wdata});
		end else begin
			dmem_rdata = dmem[addr[7:2]];
		end
	endtask

	// Data memory answers each request after 0 to 3 idle cycles
	always begin
		@(posedge clk);
		#1;
		if (rst || dmem_ready) begin
			dmem_ready = 1'b0;
			req_pending = 1'b0;
		end else if (dmem_valid) begin
			if (!req_pending) begin
				req_pending = 1'b1;
				wait_cnt = $urandom % 4;
			end
			if (wait_cnt == 0) begin
				serve_request();
				dmem_ready = 1'b1;
			end else begin
				wait_cnt--;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("watchdog timeout, the program did not reach its last store and EBREAK");
	end

	initial begin
		store_t seen;
		void'($urandom(SEED));
		clk = 1'b0;
		rst = 1'b1;
		dmem_ready = 1'b0;
		dmem_rdata = '0;
		req_pending = 1'b0;
		wait_cnt = 0;
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = 32'h5a5a_0000 ^ word_t'(i << 2);
		end
		prog = '{
			// addi x1,100; addi x2,-7; add x3; sw x3,0
			32'h06400093, 32'hff900113, 32'h002081b3, 32'h00302023,
			// sub x4; sw x4,4; and x5; or x6; xor x7
			32'h40110233, 32'h00402223, 32'h0020f2b3, 32'h0020e333, 32'h0020c3b3,
			// sw x5,8; sw x6,12; sw x7,16
			32'h00502423, 32'h00602623, 32'h00702823,
			// slt x8,x2,x1; slt x9,x1,x2; lui x10; sw x8,20; sw x9,24; sw x10,28
			32'h00112433, 32'h0020a4b3, 32'h12345537, 32'h00802a23, 32'h00902c23,
			32'h00a02e23,
			// lw x11,4; addi x0,x1,5; add x12,x11,x0; sw x12,32
			32'h00402583, 32'h00508013, 32'h00058633, 32'h02c02023,
			// beq x1,x2 not taken; bne x1,x2 taken over a wrong path sw
			32'h00208463, 32'h00209463, 32'h02102223,
			// beq x8,x8 taken over a wrong path sw; bne x9,x0 not taken
			32'h00840463, 32'h02102423, 32'h00049463,
			// jal x13,+12 skips two stores; sw x13,36; sw x1,40
			32'h00c006ef, 32'h02102623, 32'h02102823, 32'h02d02223, 32'h02102423,
			// Nothing after the EBREAK may issue
			32'h00100073, 32'h02102a23
		};
		// Address then data for each store, in program order
		exp_stores = '{
			{32'h0000_0000, 32'h0000_005d},
			{32'h0000_0004, 32'hffff_ff95},
			{32'h0000_0008, 32'h0000_0060},
			{32'h0000_000c, 32'hffff_fffd},
			{32'h0000_0010, 32'hffff_ff9d},
			{32'h0000_0014, 32'h0000_0001},
			{32'h0000_0018, 32'h0000_0000},
			{32'h0000_001c, 32'h1234_5000},
			{32'h0000_0020, 32'hffff_ff95},
			{32'h0000_0024, 32'h0000_0074},
			{32'h0000_0028, 32'h0000_0064}
		};
		repeat (RESET_CYCLES) begin
			@(posedge clk);
			#1;
			check_bit(dmem_valid, 1'b0, "dmem_valid during reset");
			check_bit(halted, 1'b0, "halted during reset");
		end
		rst = 1'b0;
		for (int i = 0; i < NUM_STORES; i++) begin
			while (seen_q.size() == 0) begin
				@(posedge clk);
			end
			seen = seen_q.pop_front();
			check_word(seen.addr, exp_stores[i].addr, $sformatf("store %0d address", i));
			check_word(seen.data, exp_stores[i].data, $sformatf("store %0d data", i));
		end
		while (!halted) begin
			@(posedge clk);
		end
		repeat (HALT_HOLD_CYCLES) begin
			@(posedge clk);
			#1;
			check_bit(halted, 1'b1, "halted after EBREAK");
			check_bit(dmem_valid, 1'b0, "dmem_valid after halt");
		end
		if (seen_q.size() != 0) begin
			fail_run("a store was issued after the last expected store");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

// File: test/cpu_assertions.sv
`timescale 1ns/1ps

module cpu_assertions (
	input logic               clk,
	input logic               rst,
	input cpu_pkg::word_t     imem_addr,
	input logic               dmem_valid,
	input cpu_pkg::dmem_req_t dmem_req,
	input logic               dmem_ready
);

	// A pending request must hold until dmem_ready
	assert property (@(posedge clk) disable iff (rst)
		dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_req))
		else $error("dmem request changed or dropped before dmem_ready");

	assert property (@(posedge clk) rst |=> !dmem_valid)
		else $error("dmem_valid high during reset");

	assert property (@(posedge clk) disable iff (rst) imem_addr[1:0] == 2'b00)
		else $error("imem_addr is not word aligned");

endmodule

bind cpu cpu_assertions i_cpu_assertions (
	.clk(clk),
	.rst(rst),
	.imem_addr(imem_addr),
	.dmem_valid(dmem_valid),
	.dmem_req(dmem_req),
	.dmem_ready(dmem_ready)
);

// File: hdl/cpu.sv
`timescale 1ns/1ps

module cpu (
	input  logic               clk,
	input  logic               rst,
	output cpu_pkg::word_t     imem_addr,
	input  cpu_pkg::word_t     imem_rdata,
	output logic               dmem_valid,
	output cpu_pkg::dmem_req_t dmem_req,
	input  logic               dmem_ready,
	input  cpu_pkg::word_t     dmem_rdata,
	output logic               halted
);
	import cpu_pkg::*;

	// Unit to unit payloads and handshakes
	fd_t fd;
	logic fd_valid;
	logic fd_ready;
	de_t de;
	logic de_valid;
	logic de_ready;
	em_t em;
	logic em_valid;
	logic em_ready;
	mw_t mw;
	logic mw_valid;
	logic mw_ready;

	// Feedback paths
	word_t npc;
	wd_t wd;
	logic retire;
	logic retire_halt;

	ifu i_ifu (
		.clk(clk),
		.rst(rst),
		.npc(npc),
		.retire(retire),
		.fd(fd),
		.fd_valid(fd_valid),
		.fd_ready(fd_ready),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.halted(halted)
	);

	idu i_idu (
		.clk(clk),
		.rst(rst),
		.fd(fd),
		.fd_valid(fd_valid),
		.fd_ready(fd_ready),
		.wd(wd),
		.de(de),
		.de_valid(de_valid),
		.de_ready(de_ready)
	);

	exeu i_exeu (
		.clk(clk),
		.rst(rst),
		.de(de),
		.de_valid(de_valid),
		.de_ready(de_ready),
		.em(em),
		.em_valid(em_valid),
		.em_ready(em_ready),
		.npc(npc)
	);

	memu i_memu (
		.clk(clk),
		.rst(rst),
		.em(em),
		.em_valid(em_valid),
		.em_ready(em_ready),
		.mw(mw),
		.mw_valid(mw_valid),
		.mw_ready(mw_ready),
		.dmem_valid(dmem_valid),
		.dmem_req(dmem_req),
		.dmem_ready(dmem_ready),
		.dmem_rdata(dmem_rdata)
	);

	wbu i_wbu (
		.clk(clk),
		.rst(rst),
		.mw(mw),
		.mw_valid(mw_valid),
		.mw_ready(mw_ready),
		.wd(wd),
		.retire(retire),
		.retire_halt(retire_halt)
	);

endmodule

// File: hdl/wbu.sv
`timescale 1ns/1ps

module wbu (
	input  logic         clk,
	input  logic         rst,
	input  cpu_pkg::mw_t mw,
	input  logic         mw_valid,
	output logic         mw_ready,
	output cpu_pkg::wd_t wd,
	output logic         retire,
	output logic         retire_halt
);
	import cpu_pkg::*;

	logic we_q;
	reg_idx_t rd_q;
	word_t wdata_q;

	// Result leaves after one cycle, so this stage never stalls
	assign mw_ready = 1'b1;
	assign wd = '{we: we_q, rd: rd_q, wdata: wdata_q};

	always_ff @(posedge clk) begin
		if (rst) begin
			we_q <= 1'b0;
			retire <= 1'b0;
			retire_halt <= 1'b0;
		end else begin
			we_q <= mw_valid && mw.reg_write;
			retire <= mw_valid;
			retire_halt <= mw_valid && mw.halt;
		end
	end

	always_ff @(posedge clk) begin
		if (mw_valid) begin
			rd_q <= mw.rd;
			wdata_q <= mw.result;
		end
	end

endmodule

// File: hdl/memu.sv
`timescale 1ns/1ps

module memu (
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::em_t       em,
	input  logic               em_valid,
	output logic               em_ready,
	output cpu_pkg::mw_t       mw,
	output logic               mw_valid,
	input  logic               mw_ready,
	output logic               dmem_valid,
	output cpu_pkg::dmem_req_t dmem_req,
	input  logic               dmem_ready,
	input  cpu_pkg::word_t     dmem_rdata
);
	import cpu_pkg::*;

	em_t em_q;
	logic accept;
	logic mem_op;
	logic mem_done;

	// No new work while a data access is outstanding
	assign em_ready = !dmem_valid && (!mw_valid || mw_ready);
	assign accept = em_valid && em_ready;
	assign mem_op = em.mem_read || em.mem_write;
	assign mem_done = dmem_valid && dmem_ready;

	// Held copy keeps the request stable until dmem_ready
	assign dmem_req = '{addr: em_q.alu_result, wdata: em_q.store_data, we: em_q.mem_write};

	always_ff @(posedge clk) begin
		if (rst) begin
			dmem_valid <= 1'b0;
			mw_valid <= 1'b0;
		end else begin
			if (accept && mem_op) begin
				dmem_valid <= 1'b1;
			end else if (mem_done) begin
				dmem_valid <= 1'b0;
			end
			if ((accept && !mem_op) || mem_done) begin
				mw_valid <= 1'b1;
			end else if (mw_ready) begin
				mw_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			em_q <= em;
		end
		if (accept && !mem_op) begin
			mw <= '{result: em.alu_result, rd: em.rd, reg_write: em.reg_write, halt: em.halt};
		end else if (mem_done) begin
			mw.result <= em_q.mem_read ? dmem_rdata : em_q.alu_result;
			mw.rd <= em_q.rd;
			mw.reg_write <= em_q.reg_write;
			mw.halt <= em_q.halt;
		end
	end

endmodule

// File: hdl/exeu.sv
`timescale 1ns/1ps

module exeu (
	input  logic           clk,
	input  logic           rst,
	input  cpu_pkg::de_t   de,
	input  logic           de_valid,
	output logic           de_ready,
	output cpu_pkg::em_t   em,
	output logic           em_valid,
	input  logic           em_ready,
	output cpu_pkg::word_t npc
);
	import cpu_pkg::*;

	word_t src_a;
	word_t src_b;
	word_t alu_out;
	word_t pc_plus4;
	logic lt;
	logic eq;
	logic taken;
	logic accept;

	assign src_a = de.src_a_pc ? de.pc : de.rs1_data;
	assign src_b = de.src_b_imm ? de.imm : de.rs2_data;
	assign lt = $signed(src_a) < $signed(src_b);
	assign eq = (de.rs1_data == de.rs2_data);
	assign pc_plus4 = de.pc + 32'd4;
	assign taken = de.jump | (de.branch_eq & eq) | (de.branch_ne & ~eq);

	assign de_ready = !em_valid || em_ready;
	assign accept = de_valid && de_ready;

	always_comb begin
		case (de.alu_op)
			alu_add: alu_out = src_a + src_b;
			alu_sub: alu_out = src_a - src_b;
			alu_and: alu_out = src_a & src_b;
			alu_or: alu_out = src_a | src_b;
			alu_xor: alu_out = src_a ^ src_b;
			alu_slt: alu_out = {31'b0, lt};
			default: alu_out = src_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			em_valid <= 1'b0;
		end else if (accept) begin
			em_valid <= 1'b1;
		end else if (em_ready) begin
			em_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			// Branch and jump targets come out of the ALU as pc + imm
			npc <= taken ? alu_out : pc_plus4;
			em.pc <= de.pc;
			em.alu_result <= de.jump ? pc_plus4 : alu_out;
			em.store_data <= de.rs2_data;
			em.rd <= de.rd;
			em.reg_write <= de.reg_write;
			em.mem_read <= de.mem_read;
			em.mem_write <= de.mem_write;
			em.link <= de.jump;
			em.halt <= de.halt;
		end
	end

endmodule

// File: hdl/idu.sv
`timescale 1ns/1ps

module idu (
	input  logic         clk,
	input  logic         rst,
	input  cpu_pkg::fd_t fd,
	input  logic         fd_valid,
	output logic         fd_ready,
	input  cpu_pkg::wd_t wd,
	output cpu_pkg::de_t de,
	output logic         de_valid,
	input  logic         de_ready
);
	import cpu_pkg::*;

	word_t regs [32];
	word_t instr;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;
	de_t dec;

	assign instr = fd.instr;
	assign opcode = instr[6:0];
	assign rd = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign funct7 = instr[31:25];

	// Sign-extended immediates
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	assign fd_ready = !de_valid || de_ready;

	always_comb begin
		dec = '0;
		dec.pc = fd.pc;
		dec.rs1_data = regs[rs1];
		dec.rs2_data = regs[rs2];
		dec.rd = rd;
		case (opcode)
			OP_IMM: begin
				dec.imm = imm_i;
				dec.src_b_imm = 1'b1;
				dec.reg_write = (funct3 == 3'b000);
			end
			OP_OP: begin
				dec.reg_write = 1'b1;
				case ({funct7, funct3})
					{7'h00, 3'b000}: dec.alu_op = alu_add;
					{7'h20, 3'b000}: dec.alu_op = alu_sub;
					{7'h00, 3'b111}: dec.alu_op = alu_and;
					{7'h00, 3'b110}: dec.alu_op = alu_or;
					{7'h00, 3'b100}: dec.alu_op = alu_xor;
					{7'h00, 3'b010}: dec.alu_op = alu_slt;
					default: dec.reg_write = 1'b0;
				endcase
			end
			OP_LUI: begin
				dec.imm = imm_u;
				dec.src_b_imm = 1'b1;
				dec.alu_op = alu_pass_b;
				dec.reg_write = 1'b1;
			end
			OP_LOAD: begin
				dec.imm = imm_i;
				dec.src_b_imm = 1'b1;
				dec.mem_read = (funct3 == 3'b010);
				dec.reg_write = (funct3 == 3'b010);
			end
			OP_STORE: begin
				dec.imm = imm_s;
				dec.src_b_imm = 1'b1;
				dec.mem_write = (funct3 == 3'b010);
			end
			OP_BRANCH: begin
				// ALU forms the target, compare is done on rs1/rs2 in execute
				dec.imm = imm_b;
				dec.src_a_pc = 1'b1;
				dec.src_b_imm = 1'b1;
				dec.branch_eq = (funct3 == 3'b000);
				dec.branch_ne = (funct3 == 3'b001);
			end
			OP_JAL: begin
				dec.imm = imm_j;
				dec.src_a_pc = 1'b1;
				dec.src_b_imm = 1'b1;
				dec.jump = 1'b1;
				dec.reg_write = 1'b1;
			end
			OP_SYSTEM: begin
				dec.halt = (instr == INSTR_EBREAK);
			end
			default: begin
				dec.reg_write = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			de_valid <= 1'b0;
		end else if (fd_valid && fd_ready) begin
			de_valid <= 1'b1;
		end else if (de_ready) begin
			de_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fd_valid && fd_ready) begin
			de <= dec;
		end
	end

	// x0 is cleared by reset and never written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wd.we && wd.rd != 5'd0) begin
			regs[wd.rd] <= wd.wdata;
		end
	end

endmodule

// File: hdl/ifu.sv
`timescale 1ns/1ps

module ifu (
	input  logic           clk,
	input  logic           rst,
	input  cpu_pkg::word_t npc,
	input  logic           retire,
	output cpu_pkg::fd_t   fd,
	output logic           fd_valid,
	input  logic           fd_ready,
	output cpu_pkg::word_t imem_addr,
	input  cpu_pkg::word_t imem_rdata,
	output logic           halted
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {
		st_fetch,
		st_wait_retire,
		st_stop
	} state_e;

	state_e state;
	word_t pc;

	assign imem_addr = pc;
	assign fd = '{pc: pc, instr: imem_rdata};
	assign halted = (state == st_stop);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_fetch;
			pc <= RESET_PC;
			fd_valid <= 1'b0;
		end else begin
			case (state)
				st_fetch: begin
					if (!fd_valid) begin
						fd_valid <= 1'b1;
					end else if (fd_ready) begin
						fd_valid <= 1'b0;
						state <= st_wait_retire;
					end
				end
				st_wait_retire: begin
					// pc is unchanged, so imem still shows the retiring word
					if (retire) begin
						if (imem_rdata == INSTR_EBREAK) begin
							state <= st_stop;
						end else begin
							pc <= npc;
							fd_valid <= 1'b1;
							state <= st_fetch;
						end
					end
				end
				default: begin
					state <= st_stop;
				end
			endcase
		end
	end

endmodule

// File: hdl/cpu_pkg.sv
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;

	localparam word_t RESET_PC = 32'h0000_0000;
	localparam word_t INSTR_EBREAK = 32'h0010_0073;

	// RV32I major opcodes
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_OP = 7'b0110011;
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_pass_b
	} alu_op_e;

	typedef struct packed {
		word_t pc;
		word_t instr;
	} fd_t;

	typedef struct packed {
		word_t pc;
		word_t rs1_data;
		word_t rs2_data;
		word_t imm;
		alu_op_e alu_op;
		logic src_a_pc;
		logic src_b_imm;
		reg_idx_t rd;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic branch_eq;
		logic branch_ne;
		logic jump;
		logic halt;
	} de_t;

	typedef struct packed {
		word_t pc;
		word_t alu_result;
		word_t store_data;
		reg_idx_t rd;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic link;
		logic halt;
	} em_t;

	typedef struct packed {
		word_t result;
		reg_idx_t rd;
		logic reg_write;
		logic halt;
	} mw_t;

	typedef struct packed {
		logic we;
		reg_idx_t rd;
		word_t wdata;
	} wd_t;

	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic we;
	} dmem_req_t;

endpackage
